//--- dv/pipeBackEndAsserts.sv
`timescale 1ns/1ps

module pipeBackEndAsserts (
    input logic        clk,
    input logic        reset,
    input logic        hostAck,
    input logic        portReq,
    input logic        req,
    input logic [31:0] memPc,
    input logic [31:0] memInstr
);
    import pipePkg::*;

    // Host ack is a single-cycle pulse
    ackPulse: assert property (@(posedge clk) disable iff (reset)
        $rose(hostAck) |=> !hostAck)
        else $error("hostAck held high for more than one cycle");

    // A memory-stage request blocks the host grant and so its ack
    pipeOwnsRam: assert property (@(posedge clk) disable iff (reset)
        portReq |=> !hostAck)
        else $error("RAM given to the host while portReq was high");

    // Flush leaves a bubble aimed at the handler
    flushBubble: assert property (@(posedge clk) disable iff (reset)
        req |=> ((memPc == ExcVector) && (memInstr == 32'h0)))
        else $error("EX/MEM slot after req is not a bubble at the exception vector");

endmodule

// Arbiter and EX/MEM register signals both live in the top level
bind pipeBackEnd pipeBackEndAsserts asserts (
    .clk      (clk),
    .reset    (reset),
    .hostAck  (hostAck),
    .portReq  (portReq),
    .req      (req),
    .memPc    (memPc),
    .memInstr (memInstr)
);

//--- dv/pipeBackEndTb.sv
`timescale 1ns/1ps

module pipeBackEndTb;
    import pipePkg::*;

    localparam int PipeWords = 32;
    localparam int HostBase  = 128;
    localparam int HostWords = 16;
    localparam int RandSlots = 300;
    localparam int HostOps   = 60;
    localparam int TimeoutCycles = 2 * (2 * PipeWords + 16 + RandSlots + 6 * HostOps) + 200;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] result;
        logic [31:0] pc;
        logic [4:0]  exc;
        logic        isDelay;
        int          due;
    } slot_t;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] exInstr, exRs, exRt, exPc;
    logic exIsDelay, we, req;
    logic hostReq, hostWrite;
    logic [RamAddrBits-1:0] hostAddr;
    logic [31:0] hostWdata;
    logic [31:0] wbInstr, wbResult, wbPc, hostRdata;
    logic [4:0] wbExcCode;
    logic wbIsDelay, hostAck;

    logic [31:0] shadow [RamWords];
    logic        hostWritten [RamWords];
    slot_t       expQ [$];
    slot_t       heldSlot;
    slot_t       wbExp;
    logic [31:0] pcNext = 32'h0000_1000;
    logic        prevPortReq = 1'b0;
    logic        hostDone = 1'b0;
    int          cycles = 0;

    pipeBackEnd dut (.*);

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model and checking
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Expected writeback slot; a good store also updates the shadow memory
    function automatic slot_t refSlot(input logic [31:0] instr, input logic [31:0] rs,
                                      input logic [31:0] rt, input logic [31:0] pc,
                                      input logic isDelay, input logic flush);
        slot_t       s;
        logic [32:0] wideSum;
        logic [31:0] addr;
        logic        bad;
        longint      prod;
        wideSum = {rs[31], rs} + {rt[31], rt};
        addr = rs + {{16{instr[15]}}, instr[15:0]};
        bad = (addr % 4 != 0) || (addr >= 32'(4 * RamWords));
        prod = longint'($signed(rs)) * longint'($signed(rt));
        s = '{instr: instr, result: 32'h0, pc: pc, exc: ExcNone, isDelay: isDelay, due: 0};
        if (flush) begin
            s.instr = 32'h0;
            s.pc = ExcVector;
            return s;
        end
        case (instr[31:26])
            OpSpecial: begin
                if (instr[5:0] == FnAddu || instr[5:0] == FnAdd) s.result = rs + rt;
                if (instr[5:0] == FnSubu) s.result = rs - rt;
                if (instr[5:0] == FnAdd && wideSum[32] != wideSum[31]) s.exc = ExcOv;
            end
            OpSpecial2: if (instr[5:0] == FnMul) s.result = prod[31:0];
            OpOri: s.result = rs | {16'h0, instr[15:0]};
            OpLui: s.result = {instr[15:0], 16'h0};
            OpLw: begin
                if (bad) s.exc = ExcAdEL;
                else s.result = shadow[addr >> 2];
            end
            OpSw: begin
                if (bad) s.exc = ExcAdES;
                else shadow[addr >> 2] = rt;
            end
            default: s.result = 32'h0;
        endcase
        if (s.exc != ExcNone) begin
            s.instr = 32'h0;
            s.result = 32'h0;
        end
        return s;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "run aborted");
        end
    end

    // Scoreboard pops one slot per edge once the pipe is full
    always @(negedge clk) begin
        if (!reset) begin
            if (hostAck) checkValue("portReq in cycle before hostAck", 32'(prevPortReq), 32'h0);
            prevPortReq = dut.portReq;
            if (expQ.size() > 0 && expQ[0].due <= cycles) begin
                wbExp = expQ.pop_front();
                checkValue("wbInstr", wbInstr, wbExp.instr);
                checkValue("wbResult", wbResult, wbExp.result);
                checkValue("wbPc", wbPc, wbExp.pc);
                checkValue("wbExcCode", 32'(wbExcCode), 32'(wbExp.exc));
                checkValue("wbIsDelay", 32'(wbIsDelay), 32'(wbExp.isDelay));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rType(input logic [5:0] op, input logic [5:0] fn);
        return {op, 5'd1, 5'd2, 5'd3, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [15:0] imm);
        return {op, 5'd4, 5'd5, imm};
    endfunction

    task automatic issueSlot(input logic [31:0] instr, input logic [31:0] rs,
                             input logic [31:0] rt, input logic advance, input logic flush);
        logic  delay;
        slot_t e;
        delay = 1'($urandom_range(0, 1));
        @(posedge clk);
        exInstr <= instr;
        exRs <= rs;
        exRt <= rt;
        exPc <= pcNext;
        exIsDelay <= delay;
        we <= advance;
        req <= flush;
        if (advance || flush) heldSlot = refSlot(instr, rs, rt, pcNext, delay, flush);
        // Visible in writeback two edges later
        e = heldSlot;
        e.due = cycles + 3;
        expQ.push_back(e);
        pcNext = pcNext + 4;
    endtask

    task automatic randomSlot();
        int          kind;
        int          off;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        kind = $urandom_range(0, 15);
        a = $urandom();
        b = $urandom();
        off = $urandom_range(0, 63) * 4 - 128;
        base = 32'($urandom_range(0, PipeWords - 1) * 4 - off);
        // Occasional misaligned or out-of-range access
        if ($urandom_range(0, 7) == 0) begin
            if ($urandom_range(0, 1) == 1) base = base + $urandom_range(1, 3);
            else base = base + 32'h400;
        end
        case (kind)
            0, 1:     issueSlot(rType(OpSpecial, FnAddu), a, b, 1'b1, 1'b0);
            2:        issueSlot(rType(OpSpecial, FnSubu), a, b, 1'b1, 1'b0);
            3:        issueSlot(rType(OpSpecial, FnAdd), a, b, 1'b1, 1'b0);
            4:        issueSlot(iType(OpOri, b[15:0]), a, b, 1'b1, 1'b0);
            5:        issueSlot(iType(OpLui, b[15:0]), a, b, 1'b1, 1'b0);
            6:        issueSlot(rType(OpSpecial2, FnMul), a, b, 1'b1, 1'b0);
            7, 8, 9:  issueSlot(iType(OpLw, off[15:0]), base, b, 1'b1, 1'b0);
            10, 11:   issueSlot(iType(OpSw, off[15:0]), base, b, 1'b1, 1'b0);
            12:       issueSlot(rType(OpSpecial, FnAddu), a, b, 1'b0, 1'b0);
            13:       issueSlot(iType(OpOri, b[15:0]), a, b, 1'b1, 1'b1);
            default:  issueSlot(32'h0, a, b, 1'b1, 1'b0);
        endcase
    endtask

    task automatic runPipeline();
        for (int w = 0; w < PipeWords; w++) begin
            issueSlot(iType(OpSw, 16'h0), w * 4, $urandom(), 1, 0);
        end
        for (int w = 0; w < PipeWords; w++) begin
            issueSlot(iType(OpLw, 16'h0), w * 4, 0, 1, 0);
        end
        // Faults and a readback showing faulting stores left the RAM alone
        issueSlot(rType(OpSpecial, FnAdd), 32'h7fff_ffff, 32'h1, 1, 0);
        issueSlot(iType(OpLw, 16'h0), 32'h5, 0, 1, 0);
        issueSlot(iType(OpLw, 16'h0), 32'h400, 0, 1, 0);
        issueSlot(iType(OpSw, 16'h0), 32'h9, 32'hdead_beef, 1, 0);
        issueSlot(iType(OpSw, 16'h0), 32'h400, 32'hcafe_f00d, 1, 0);
        issueSlot(iType(OpLw, 16'h0), 32'h8, 0, 1, 0);
        issueSlot(iType(OpLw, 16'h0), 32'h0, 0, 1, 0);
        // Flush followed by two stall cycles
        issueSlot(iType(OpLw, 16'h4), 32'h0, 0, 1, 1);
        issueSlot(rType(OpSpecial, FnAddu), 32'h1, 32'h2, 0, 0);
        issueSlot(rType(OpSpecial, FnAddu), 32'h3, 32'h4, 0, 0);
        repeat (RandSlots) randomSlot();
        while (!hostDone) issueSlot(32'h0, 0, 0, 1, 0);
    endtask

    task automatic hostAccess(input logic write, input logic [RamAddrBits-1:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        @(posedge clk);
        hostReq <= 1'b1;
        hostWrite <= write;
        hostAddr <= addr;
        hostWdata <= data;
        do @(negedge clk); while (!hostAck);
        rdata = hostRdata;
        @(posedge clk);
        hostReq <= 1'b0;
    endtask

    task automatic runHost();
        logic [RamAddrBits-1:0] addr;
        logic [31:0]            data;
        logic [31:0]            rdata;
        for (int i = 0; i < HostOps; i++) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            addr = RamAddrBits'(HostBase + $urandom_range(0, HostWords - 1));
            data = $urandom();
            if (!hostWritten[addr] || $urandom_range(0, 1) == 1) begin
                hostAccess(1'b1, addr, data, rdata);
                shadow[addr] = data;
                hostWritten[addr] = 1'b1;
            end else begin
                hostAccess(1'b0, addr, 32'h0, rdata);
                checkValue("hostRdata", rdata, shadow[addr]);
            end
        end
        hostDone = 1'b1;
    endtask

    initial begin
        void'($urandom(32'hb0fd0df6));
        foreach (hostWritten[i]) hostWritten[i] = 1'b0;
        heldSlot = '{instr: 32'h0, result: 32'h0, pc: 32'h0, exc: ExcNone, isDelay: 1'b0, due: 0};
        reset = 1'b1;
        {exInstr, exRs, exRt, exPc, exIsDelay, we, req} = '0;
        {hostReq, hostWrite, hostAddr, hostWdata} = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        fork
            runPipeline();
            runHost();
        join
        @(posedge clk);
        we <= 1'b0;
        req <= 1'b0;
        while (expQ.size() != 0) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verilog/dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            writeEn,
    input  logic [pipePkg::RamAddrBits-1:0] addr,
    input  logic [31:0]                     wdata,
    output logic [31:0]                     rdata
);
    import pipePkg::*;

    logic [31:0] mem [RamWords];

    // Single port, write takes the cycle, read data is one edge late
    always_ff @(posedge clk) begin
        if (en) begin
            if (writeEn) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- verilog/exMemReg.sv
`timescale 1ns/1ps

module exMemReg (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic        req,
    input  logic [31:0] exInstr,
    input  logic [31:0] exAluResult,
    input  logic [31:0] exMduResult,
    input  logic [31:0] exRd2,
    input  logic [31:0] exPc,
    input  logic [4:0]  exExcCode,
    input  logic        exIsDelay,
    output logic [31:0] memInstr,
    output logic [31:0] memAluResult,
    output logic [31:0] memMduResult,
    output logic [31:0] memRd2,
    output logic [31:0] memPc,
    output logic [4:0]  memExcCode,
    output logic        memIsDelay
);
    import pipePkg::*;

    // Priority is reset, then flush, then advance; otherwise hold
    always_ff @(posedge clk) begin
        if (reset) begin
            memInstr     <= 32'h0;
            memAluResult <= 32'h0;
            memMduResult <= 32'h0;
            memRd2       <= 32'h0;
            memPc        <= 32'h0;
            memExcCode   <= ExcNone;
            memIsDelay   <= 1'b0;
        end else if (req) begin
            // Bubble headed for the handler, delay-slot bit survives
            memInstr     <= 32'h0;
            memAluResult <= 32'h0;
            memMduResult <= 32'h0;
            memRd2       <= 32'h0;
            memPc        <= ExcVector;
            memExcCode   <= ExcNone;
            memIsDelay   <= exIsDelay;
        end else if (we) begin
            // A faulting instruction turns into a nop but keeps its code
            memInstr     <= (exExcCode != ExcNone) ? 32'h0 : exInstr;
            memAluResult <= exAluResult;
            memMduResult <= exMduResult;
            memRd2       <= exRd2;
            memPc        <= exPc;
            memExcCode   <= exExcCode;
            memIsDelay   <= exIsDelay;
        end
    end

endmodule

//--- verilog/execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic [31:0] instr,
    input  logic [31:0] rs,
    input  logic [31:0] rt,
    output logic [31:0] aluResult,
    output logic [31:0] mduResult,
    output logic [31:0] rd2,
    output logic [4:0]  excCode
);
    import pipePkg::*;

    // Top of the byte address space backed by the RAM
    localparam logic [31:0] RamLimit = 32'(RamWords * 4);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [15:0]        imm;
    logic [31:0]        immSext;
    logic [31:0]        immZext;

    logic [31:0]        sum;
    logic [31:0]        diff;
    logic [31:0]        effAddr;
    logic signed [63:0] product;

    logic               isAdd;
    logic               isAddu;
    logic               isSubu;
    logic               isMul;
    logic               isLoad;
    logic               isStore;
    logic               overflow;
    logic               addrBad;

    //////////////////////////////////////////////////////////////////////
    // Field extraction and decode
    //////////////////////////////////////////////////////////////////////

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign imm     = instr[15:0];
    assign immSext = {{16{imm[15]}}, imm};
    assign immZext = {16'h0000, imm};

    assign isAdd   = (opcode == OpSpecial)  && (funct == FnAdd);
    assign isAddu  = (opcode == OpSpecial)  && (funct == FnAddu);
    assign isSubu  = (opcode == OpSpecial)  && (funct == FnSubu);
    assign isMul   = (opcode == OpSpecial2) && (funct == FnMul);
    assign isLoad  = (opcode == OpLw);
    assign isStore = (opcode == OpSw);

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    assign sum     = rs + rt;
    assign diff    = rs - rt;
    assign effAddr = rs + immSext;

    // Only the low word of the signed product is architecturally visible
    assign product   = $signed(rs) * $signed(rt);
    assign mduResult = isMul ? product[31:0] : 32'h0;

    // Store data goes down the pipe untouched
    assign rd2 = rt;

    always_comb begin
        unique case (opcode)
            OpSpecial: begin
                if (isAdd || isAddu) begin
                    aluResult = sum;
                end else if (isSubu) begin
                    aluResult = diff;
                end else begin
                    aluResult = 32'h0;
                end
            end
            OpOri:      aluResult = rs | immZext;
            OpLui:      aluResult = {imm, 16'h0000};
            OpLw, OpSw: aluResult = effAddr;
            // Unknown opcodes fall through as a nop
            default:    aluResult = 32'h0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Exception detection
    //////////////////////////////////////////////////////////////////////

    // Signed overflow: same operand signs, different result sign
    assign overflow = isAdd && (rs[31] == rt[31]) && (sum[31] != rs[31]);

    // Misaligned word or beyond the RAM
    assign addrBad = (effAddr[1:0] != 2'b00) || (effAddr >= RamLimit);

    always_comb begin
        if (overflow) begin
            excCode = ExcOv;
        end else if (isLoad && addrBad) begin
            excCode = ExcAdEL;
        end else if (isStore && addrBad) begin
            excCode = ExcAdES;
        end else begin
            excCode = ExcNone;
        end
    end

endmodule

//--- verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            portReq,
    input  logic                            portWrite,
    input  logic [pipePkg::RamAddrBits-1:0] portAddr,
    input  logic [31:0]                     portWdata,
    input  logic                            hostReq,
    input  logic                            hostWrite,
    input  logic [pipePkg::RamAddrBits-1:0] hostAddr,
    input  logic [31:0]                     hostWdata,
    input  logic [31:0]                     ramRdata,
    output logic [31:0]                     portRdata,
    output logic [31:0]                     hostRdata,
    output logic                            hostAck,
    output logic                            ramEn,
    output logic                            ramWe,
    output logic [pipePkg::RamAddrBits-1:0] ramAddr,
    output logic [31:0]                     ramWdata
);

    logic hostSel;

    // Pipeline always wins; host must not be re-granted during its ack
    assign hostSel = hostReq && !portReq && !hostAck;

    always_comb begin
        if (portReq) begin
            ramEn    = 1'b1;
            ramWe    = portWrite;
            ramAddr  = portAddr;
            ramWdata = portWdata;
        end else begin
            ramEn    = hostSel;
            ramWe    = hostSel && hostWrite;
            ramAddr  = hostAddr;
            ramWdata = hostWdata;
        end
    end

    // Ack lines up with the registered RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            hostAck <= 1'b0;
        end else begin
            hostAck <= hostSel;
        end
    end

    // Each reader knows when its own data is valid
    assign portRdata = ramRdata;
    assign hostRdata = ramRdata;

endmodule

//--- verilog/memStage.sv
`timescale 1ns/1ps

module memStage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   memInstr,
    input  logic [31:0]                   memAluResult,
    input  logic [31:0]                   memMduResult,
    input  logic [31:0]                   memRd2,
    input  logic [31:0]                   memPc,
    input  logic [4:0]                    memExcCode,
    input  logic                          memIsDelay,
    input  logic [31:0]                   portRdata,
    output logic                          portReq,
    output logic                          portWrite,
    output logic [pipePkg::RamAddrBits-1:0] portAddr,
    output logic [31:0]                   portWdata,
    output logic [31:0]                   wbInstr,
    output logic [31:0]                   wbResult,
    output logic [31:0]                   wbPc,
    output logic [4:0]                    wbExcCode,
    output logic                          wbIsDelay
);
    import pipePkg::*;

    // Which source feeds the writeback result
    typedef enum logic [1:0] {
        SelAlu,
        SelMdu,
        SelLoad,
        SelZero
    } resSel_t;

    logic [5:0]  opcode;
    logic        isLoad;
    logic        isStore;
    logic        isMul;
    resSel_t     nextSel;

    resSel_t     wbSel;
    logic [31:0] wbAlu;
    logic [31:0] wbMdu;

    //////////////////////////////////////////////////////////////////////
    // RAM request
    //////////////////////////////////////////////////////////////////////

    assign opcode  = memInstr[31:26];
    assign isLoad  = (opcode == OpLw);
    assign isStore = (opcode == OpSw);
    assign isMul   = (opcode == OpSpecial2) && (memInstr[5:0] == FnMul);

    // Faulting accesses were already nopped, so only good ones get here
    assign portReq   = isLoad || isStore;
    assign portWrite = isStore;
    assign portAddr  = memAluResult[RamAddrBits+1:2];
    assign portWdata = memRd2;

    always_comb begin
        if (isLoad) begin
            nextSel = SelLoad;
        end else if (isMul) begin
            nextSel = SelMdu;
        end else if (isStore || (memInstr == 32'h0)) begin
            nextSel = SelZero;
        end else begin
            nextSel = SelAlu;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory-to-writeback register, captures every cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wbInstr   <= 32'h0;
            wbPc      <= 32'h0;
            wbExcCode <= ExcNone;
            wbIsDelay <= 1'b0;
            wbSel     <= SelZero;
            wbAlu     <= 32'h0;
            wbMdu     <= 32'h0;
        end else begin
            wbInstr   <= memInstr;
            wbPc      <= memPc;
            wbExcCode <= memExcCode;
            wbIsDelay <= memIsDelay;
            wbSel     <= nextSel;
            wbAlu     <= memAluResult;
            wbMdu     <= memMduResult;
        end
    end

    // Load data arrives from the RAM output register this cycle
    always_comb begin
        unique case (wbSel)
            SelLoad: wbResult = portRdata;
            SelMdu:  wbResult = wbMdu;
            SelAlu:  wbResult = wbAlu;
            default: wbResult = 32'h0;
        endcase
    end

endmodule

//--- verilog/pipeBackEnd.sv
`timescale 1ns/1ps

module pipeBackEnd (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [31:0]                     exInstr,
    input  logic [31:0]                     exRs,
    input  logic [31:0]                     exRt,
    input  logic [31:0]                     exPc,
    input  logic                            exIsDelay,
    input  logic                            we,
    input  logic                            req,
    input  logic                            hostReq,
    input  logic                            hostWrite,
    input  logic [pipePkg::RamAddrBits-1:0] hostAddr,
    input  logic [31:0]                     hostWdata,
    output logic [31:0]                     wbInstr,
    output logic [31:0]                     wbResult,
    output logic [31:0]                     wbPc,
    output logic [4:0]                      wbExcCode,
    output logic                            wbIsDelay,
    output logic [31:0]                     hostRdata,
    output logic                            hostAck
);
    import pipePkg::*;

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    logic [31:0] aluResult;
    logic [31:0] mduResult;
    logic [31:0] exRd2;
    logic [4:0]  excCode;

    execStage execStage (
        .instr     (exInstr),
        .rs        (exRs),
        .rt        (exRt),
        .aluResult (aluResult),
        .mduResult (mduResult),
        .rd2       (exRd2),
        .excCode   (excCode)
    );

    logic [31:0] memInstr;
    logic [31:0] memAluResult;
    logic [31:0] memMduResult;
    logic [31:0] memRd2;
    logic [31:0] memPc;
    logic [4:0]  memExcCode;
    logic        memIsDelay;

    exMemReg exMemReg (
        .clk          (clk),
        .reset        (reset),
        .we           (we),
        .req          (req),
        .exInstr      (exInstr),
        .exAluResult  (aluResult),
        .exMduResult  (mduResult),
        .exRd2        (exRd2),
        .exPc         (exPc),
        .exExcCode    (excCode),
        .exIsDelay    (exIsDelay),
        .memInstr     (memInstr),
        .memAluResult (memAluResult),
        .memMduResult (memMduResult),
        .memRd2       (memRd2),
        .memPc        (memPc),
        .memExcCode   (memExcCode),
        .memIsDelay   (memIsDelay)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////////////////////////

    logic                   portReq;
    logic                   portWrite;
    logic [RamAddrBits-1:0] portAddr;
    logic [31:0]            portWdata;
    logic [31:0]            portRdata;

    memStage memStage (
        .clk          (clk),
        .reset        (reset),
        .memInstr     (memInstr),
        .memAluResult (memAluResult),
        .memMduResult (memMduResult),
        .memRd2       (memRd2),
        .memPc        (memPc),
        .memExcCode   (memExcCode),
        .memIsDelay   (memIsDelay),
        .portRdata    (portRdata),
        .portReq      (portReq),
        .portWrite    (portWrite),
        .portAddr     (portAddr),
        .portWdata    (portWdata),
        .wbInstr      (wbInstr),
        .wbResult     (wbResult),
        .wbPc         (wbPc),
        .wbExcCode    (wbExcCode),
        .wbIsDelay    (wbIsDelay)
    );

    // RAM side of the arbiter
    logic                   ramEn;
    logic                   ramWe;
    logic [RamAddrBits-1:0] ramAddr;
    logic [31:0]            ramWdata;
    logic [31:0]            ramRdata;

    memArbiter memArbiter (
        .clk       (clk),
        .reset     (reset),
        .portReq   (portReq),
        .portWrite (portWrite),
        .portAddr  (portAddr),
        .portWdata (portWdata),
        .hostReq   (hostReq),
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .ramRdata  (ramRdata),
        .portRdata (portRdata),
        .hostRdata (hostRdata),
        .hostAck   (hostAck),
        .ramEn     (ramEn),
        .ramWe     (ramWe),
        .ramAddr   (ramAddr),
        .ramWdata  (ramWdata)
    );

    dataRam dataRam (
        .clk     (clk),
        .en      (ramEn),
        .writeEn (ramWe),
        .addr    (ramAddr),
        .wdata   (ramWdata),
        .rdata   (ramRdata)
    );

endmodule

//--- verilog/pipePkg.sv
package pipePkg;

    //////////////////////////////////////////////////////////////////////
    // Primary opcodes, instr[31:26]
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OpSpecial  = 6'h00;
    localparam logic [5:0] OpSpecial2 = 6'h1c;
    localparam logic [5:0] OpOri      = 6'h0d;
    localparam logic [5:0] OpLui      = 6'h0f;
    localparam logic [5:0] OpLw       = 6'h23;
    localparam logic [5:0] OpSw       = 6'h2b;

    //////////////////////////////////////////////////////////////////////
    // Function codes, instr[5:0]
    //////////////////////////////////////////////////////////////////////

    // SPECIAL group
    localparam logic [5:0] FnAdd  = 6'h20;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;

    // SPECIAL2 group
    localparam logic [5:0] FnMul  = 6'h02;

    //////////////////////////////////////////////////////////////////////
    // Exception codes as seen by CP0 Cause.ExcCode
    //////////////////////////////////////////////////////////////////////

    localparam logic [4:0] ExcNone = 5'd0;
    localparam logic [4:0] ExcAdEL = 5'd4;
    localparam logic [4:0] ExcAdES = 5'd5;
    localparam logic [4:0] ExcOv   = 5'd12;

    // Handler entry, loaded into the slot PC on a flush
    localparam logic [31:0] ExcVector = 32'h0000_4180;

    //////////////////////////////////////////////////////////////////////
    // Data RAM geometry
    //////////////////////////////////////////////////////////////////////

    localparam int RamWords    = 256;
    localparam int RamAddrBits = $clog2(RamWords);

endpackage

//--- vlog.f
verilog/pipePkg.sv
verilog/execStage.sv
verilog/exMemReg.sv
verilog/memStage.sv
verilog/memArbiter.sv
verilog/dataRam.sv
verilog/pipeBackEnd.sv
dv/pipeBackEndAsserts.sv
dv/pipeBackEndTb.sv
